//--- Bender.yml
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/mem_rd_pkg.sv
  - source/icache_line_store.sv
  - source/icache_ctrl.sv
  - source/icache_perf.sv
  - source/icache_top.sv
  - target: test
    files:
      - verification/mem_burst_model.sv
      - verification/tb_icache.sv

//--- source/icache_ctrl.sv
module icache_ctrl
  import icache_pkg::*;
  import mem_rd_pkg::*;
#(
  parameter int offset_w = offset_w_def,
  parameter int index_w  = index_w_def
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         flush,
  input  logic                         ifu_arvalid,
  output logic                         ifu_arready,
  input  logic [31:0]                  ifu_araddr,
  output logic                         ifu_rvalid,
  input  logic                         ifu_rready,
  output logic [31:0]                  ifu_rdata,
  output logic                         mem_arvalid,
  input  logic                         mem_arready,
  output logic [31:0]                  mem_araddr,
  output mem_len_t                     mem_arlen,
  output burst_kind_e                  mem_arburst,
  input  logic                         mem_rvalid,
  input  mem_data_t                    mem_rdata,
  input  logic                         mem_rlast,
  output logic [31:0]                  lookup_addr,
  input  logic                         hit,
  input  logic [31:0]                  rd_word,
  output logic                         flush_all,
  output logic                         wr_en,
  output logic [index_w-1:0]           wr_index,
  output logic [offset_w-3:0]          wr_word_sel,
  output logic [31:0]                  wr_word,
  output logic                         tag_wr_en,
  output logic [31-offset_w-index_w:0] wr_tag,
  output logic                         ev_hit,
  output logic                         ev_miss,
  output logic                         ev_bypass
);

  localparam int word_w = offset_w - 2;
  localparam int words  = 1 << word_w;

  ctrl_state_e state_q, state_d;

  logic [31:0]       addr_q;
  logic [word_w-1:0] ptr_q;     // wrapping word pointer
  mem_len_t          beat_cnt_q;
  mem_len_t          len_q;     // beats issued, minus one
  logic [31:0]       rdata_q;
  logic              bypass_q;
  logic              flush_pend_q;

  logic        accept;
  logic        cacheable;
  logic        beat;
  logic [31:0] lane_word;

  assign accept    = ifu_arvalid && ifu_arready;
  assign cacheable = ifu_araddr[31:28] >= cacheable_base_nibble;
  assign beat      = mem_rvalid && (state_q == refill || state_q == bypass_wait);
  assign lane_word = ptr_q[0] ? mem_rdata[63:32] : mem_rdata[31:0]; // lane by addr bit 2

  assign ifu_arready = (state_q == idle);
  assign ifu_rvalid  = (state_q == lookup_resp) || (state_q == resp);
  assign ifu_rdata   = (state_q == lookup_resp) ? rd_word : rdata_q;
  assign lookup_addr = (state_q == idle) ? ifu_araddr : addr_q;

  assign mem_arvalid = (state_q == burst_req) || (state_q == bypass_req);
  assign mem_araddr  = addr_q;
  assign mem_arlen   = (state_q == burst_req) ? mem_len_t'(words - 1) : '0;
  assign mem_arburst = (state_q == burst_req) ? wrap : incr;

  assign flush_all   = (state_q == idle) && !accept && (flush || flush_pend_q);
  assign wr_en       = (state_q == refill) && mem_rvalid;
  assign wr_index    = addr_q[offset_w+index_w-1:offset_w];
  assign wr_word_sel = ptr_q;
  assign wr_word     = lane_word;
  assign tag_wr_en   = wr_en && mem_rlast; // line complete
  assign wr_tag      = addr_q[31:offset_w+index_w];

  assign ev_hit    = (state_q == lookup_resp) && ifu_rready;
  assign ev_miss   = (state_q == resp) && ifu_rready && !bypass_q;
  assign ev_bypass = (state_q == resp) && ifu_rready && bypass_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (accept) begin
          if (!cacheable)
            state_d = bypass_req;
          else if (hit)
            state_d = lookup_resp;
          else
            state_d = burst_req;
        end
      end
      lookup_resp: if (ifu_rready) state_d = idle;
      burst_req:   if (mem_arready) state_d = refill;
      refill:      if (mem_rvalid && mem_rlast) state_d = resp;
      bypass_req:  if (mem_arready) state_d = bypass_wait;
      bypass_wait: if (mem_rvalid) state_d = resp; // single beat
      resp:        if (ifu_rready) state_d = idle;
      default:     state_d = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q      <= idle;
      flush_pend_q <= 1'b0;
      bypass_q     <= 1'b0;
      beat_cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (flush_all)
        flush_pend_q <= 1'b0;
      else if (flush)
        flush_pend_q <= 1'b1; // wait for a free idle cycle
      if (accept) begin
        bypass_q   <= !cacheable;
        beat_cnt_q <= '0;
      end else if (beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= {ifu_araddr[31:2], 2'b00};
      ptr_q  <= ifu_araddr[offset_w-1:2];
    end else if (wr_en) begin
      ptr_q <= ptr_q + 1'b1; // wraps inside the line
    end
    if (mem_arvalid && mem_arready)
      len_q <= mem_arlen;
    if (beat && (state_q == bypass_wait || beat_cnt_q == '0))
      rdata_q <= lane_word; // critical word comes first
  end

  a_resp_hold: assert property (
    @(posedge clk) disable iff (!rstn)
    ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata)
  ) else $error("fetch response dropped or changed before rready");

  a_rvalid_expected: assert property (
    @(posedge clk) disable iff (!rstn)
    mem_rvalid |-> (state_q == refill || state_q == bypass_wait)
  ) else $error("memory beat with no burst outstanding");

  a_rlast_count: assert property (
    @(posedge clk) disable iff (!rstn)
    beat |-> (mem_rlast == (beat_cnt_q == len_q))
  ) else $error("rlast does not match issued burst length");

endmodule

//--- source/icache_line_store.sv
module icache_line_store
  import icache_pkg::*;
#(
  parameter int offset_w = offset_w_def,
  parameter int index_w  = index_w_def
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         flush_all,
  input  logic [31:0]                  lookup_addr,
  input  logic                         wr_en,
  input  logic [index_w-1:0]           wr_index,
  input  logic [offset_w-3:0]          wr_word_sel,
  input  logic [31:0]                  wr_word,
  input  logic                         tag_wr_en,
  input  logic [31-offset_w-index_w:0] wr_tag,
  output logic                         hit,
  output logic [31:0]                  rd_word
);

  localparam int tag_w  = 32 - offset_w - index_w;
  localparam int word_w = offset_w - 2;
  localparam int lines  = 1 << index_w;
  localparam int words  = 1 << word_w;

  logic [lines-1:0]  valid_q;
  logic [tag_w-1:0]  tag_q  [lines];
  logic [31:0]       data_q [lines][words];

  logic [index_w-1:0] lk_index;
  logic [tag_w-1:0]   lk_tag;
  logic [word_w-1:0]  lk_word;

  assign lk_index = lookup_addr[offset_w+index_w-1:offset_w];
  assign lk_tag   = lookup_addr[31:offset_w+index_w];
  assign lk_word  = lookup_addr[offset_w-1:2];

  assign hit     = valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
  assign rd_word = data_q[lk_index][lk_word];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= '0;
    end else if (flush_all) begin
      valid_q <= '0; // wins over a tag write
    end else if (tag_wr_en) begin
      valid_q[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wr_en) begin
      tag_q[wr_index] <= wr_tag;
    end
    if (wr_en) begin
      data_q[wr_index][wr_word_sel] <= wr_word; // one word per beat
    end
  end

  // flush is only taken while the controller sits idle, refill never overlaps
  a_no_flush_during_write: assert property (
    @(posedge clk) disable iff (!rstn) !(wr_en && flush_all)
  ) else $error("line store written during flush");

endmodule

//--- source/icache_perf.sv
module icache_perf
  import icache_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      ev_hit,
  input  logic      ev_miss,
  input  logic      ev_bypass,
  output perf_cnt_t perf_hit,
  output perf_cnt_t perf_miss,
  output perf_cnt_t perf_bypass
);

  // holds at all ones instead of wrapping
  function automatic perf_cnt_t sat_inc(perf_cnt_t cnt, logic ev);
    if (ev && (cnt != '1))
      return cnt + 1'b1;
    return cnt;
  endfunction

  always_ff @(posedge clk) begin
    if (!rstn) begin
      perf_hit    <= '0;
      perf_miss   <= '0;
      perf_bypass <= '0;
    end else begin
      perf_hit    <= sat_inc(perf_hit, ev_hit);
      perf_miss   <= sat_inc(perf_miss, ev_miss);
      perf_bypass <= sat_inc(perf_bypass, ev_bypass);
    end
  end

  // only one response can complete per cycle
  a_one_event: assert property (
    @(posedge clk) disable iff (!rstn) $onehot0({ev_hit, ev_miss, ev_bypass})
  ) else $error("more than one perf event in a cycle");

endmodule

//--- source/icache_pkg.sv
package icache_pkg;

  // default cache geometry
  localparam int offset_w_def = 4; // 16 byte lines, four words
  localparam int index_w_def  = 2; // four lines

  // fetches at or above this top nibble go through the cache
  localparam logic [3:0] cacheable_base_nibble = 4'h3; // below is on-chip sram

  typedef enum logic [2:0] {
    idle        = 3'd0,
    lookup_resp = 3'd1, // hit word straight from the line store
    burst_req   = 3'd2,
    refill      = 3'd3,
    bypass_req  = 3'd4,
    bypass_wait = 3'd5,
    resp        = 3'd6  // registered word after memory access
  } ctrl_state_e;

  typedef logic [31:0] perf_cnt_t;

endpackage

//--- source/icache_top.sv
module icache_top
  import icache_pkg::*;
  import mem_rd_pkg::*;
#(
  parameter int offset_w = offset_w_def,
  parameter int index_w  = index_w_def
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        flush,
  input  logic        ifu_arvalid,
  output logic        ifu_arready,
  input  logic [31:0] ifu_araddr,
  output logic        ifu_rvalid,
  input  logic        ifu_rready,
  output logic [31:0] ifu_rdata,
  output logic        mem_arvalid,
  input  logic        mem_arready,
  output logic [31:0] mem_araddr,
  output mem_len_t    mem_arlen,
  output burst_kind_e mem_arburst,
  input  logic        mem_rvalid,
  input  mem_data_t   mem_rdata,
  input  logic        mem_rlast,
  output perf_cnt_t   perf_hit,
  output perf_cnt_t   perf_miss,
  output perf_cnt_t   perf_bypass
);

  logic [31:0]                  lookup_addr;
  logic                         hit;
  logic [31:0]                  rd_word;
  logic                         flush_all;
  logic                         wr_en;
  logic [index_w-1:0]           wr_index;
  logic [offset_w-3:0]          wr_word_sel;
  logic [31:0]                  wr_word;
  logic                         tag_wr_en;
  logic [31-offset_w-index_w:0] wr_tag;
  logic                         ev_hit;
  logic                         ev_miss;
  logic                         ev_bypass;

  icache_ctrl #(
    .offset_w (offset_w),
    .index_w  (index_w)
  ) u_ctrl (
    .clk, .rstn, .flush,
    .ifu_arvalid, .ifu_arready, .ifu_araddr,
    .ifu_rvalid, .ifu_rready, .ifu_rdata,
    .mem_arvalid, .mem_arready, .mem_araddr, .mem_arlen, .mem_arburst,
    .mem_rvalid, .mem_rdata, .mem_rlast,
    .lookup_addr, .hit, .rd_word, .flush_all,
    .wr_en, .wr_index, .wr_word_sel, .wr_word, .tag_wr_en, .wr_tag,
    .ev_hit, .ev_miss, .ev_bypass
  );

  icache_line_store #(
    .offset_w (offset_w),
    .index_w  (index_w)
  ) u_line_store (
    .clk, .rstn, .flush_all, .lookup_addr,
    .wr_en, .wr_index, .wr_word_sel, .wr_word, .tag_wr_en, .wr_tag,
    .hit, .rd_word
  );

  icache_perf u_perf (
    .clk, .rstn, .ev_hit, .ev_miss, .ev_bypass,
    .perf_hit, .perf_miss, .perf_bypass
  );

endmodule

//--- source/mem_rd_pkg.sv
package mem_rd_pkg;

  localparam int mem_data_w = 64;

  // axi burst encodings, fixed bursts are never issued
  typedef enum logic [1:0] {
    incr = 2'b01,
    wrap = 2'b10
  } burst_kind_e;

  typedef logic [7:0] mem_len_t; // beats minus one

  // word with address bit 2 set travels in the upper lane
  typedef logic [mem_data_w-1:0] mem_data_t;

endpackage

//--- src.f
source/icache_pkg.sv
source/mem_rd_pkg.sv
source/icache_line_store.sv
source/icache_ctrl.sv
source/icache_perf.sv
source/icache_top.sv
verification/mem_burst_model.sv
verification/tb_icache.sv

//--- verification/mem_burst_model.sv
module mem_burst_model
  import mem_rd_pkg::*;
#(
  parameter int          line_words = 4,
  parameter int unsigned seed       = 1
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        mem_arvalid,
  output logic        mem_arready,
  input  logic [31:0] mem_araddr,
  input  mem_len_t    mem_arlen,
  input  burst_kind_e mem_arburst,
  output logic        mem_rvalid,
  output mem_data_t   mem_rdata,
  output logic        mem_rlast,
  input  logic [31:0] exp_addr,
  input  logic        exp_single,
  output logic        burst_err
);

  localparam int line_bytes = line_words * 4;

  int unsigned rng_state = seed;

  function automatic logic [15:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[30:15];
  endfunction

  // memory contents, a pure function of the word address
  function automatic logic [31:0] word_mix(logic [31:0] addr);
    logic [31:0] w;
    w = {addr[31:2], 2'b00};
    return (w * 32'h9e3779b1) ^ {w[15:0], w[31:16]} ^ 32'h5a0f_c3a5;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic flag_bad_burst(string what);
    $display("Error at time %0t: %s", $time, what);
    burst_err = 1'b1;
  endtask

  task automatic serve_burst();
    logic [31:0] addr;
    mem_len_t    len;
    burst_kind_e kind;
    logic [31:0] line_base;
    logic [31:0] beat_addr;
    repeat (lcg_next() % 4) next_cycle(); // arready latency
    mem_arready = 1'b1;
    addr = mem_araddr;
    len  = mem_arlen;
    kind = mem_arburst;
    next_cycle();
    mem_arready = 1'b0;
    if (addr != exp_addr)
      flag_bad_burst("memory read does not start at the requested word");
    if (exp_single && (len != 0 || kind != incr))
      flag_bad_burst("bypass read is not a single-beat incr burst");
    if (!exp_single && (len != mem_len_t'(line_words - 1) || kind != wrap))
      flag_bad_burst("cacheable read is not a full-line wrap burst");
    line_base = addr & ~32'(line_bytes - 1);
    for (int i = 0; i <= int'(len); i++) begin
      repeat (lcg_next() % 3) next_cycle(); // beat gap
      if (kind == wrap)
        beat_addr = line_base | ((addr + 32'(4 * i)) & 32'(line_bytes - 1));
      else
        beat_addr = addr + 32'(4 * i);
      mem_rvalid = 1'b1;
      mem_rlast  = (i == int'(len));
      // unused lane carries the inverted word
      if (beat_addr[2])
        mem_rdata = {word_mix(beat_addr), ~word_mix(beat_addr)};
      else
        mem_rdata = {~word_mix(beat_addr), word_mix(beat_addr)};
      next_cycle();
      mem_rvalid = 1'b0;
      mem_rlast  = 1'b0;
    end
  endtask

  initial begin
    mem_arready = 1'b0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    mem_rlast   = 1'b0;
    burst_err   = 1'b0;
    forever begin
      next_cycle();
      if (rstn && mem_arvalid)
        serve_burst();
    end
  end

endmodule

//--- verification/tb_icache.sv
module tb_icache
  import icache_pkg::*;
  import mem_rd_pkg::*;
();

  localparam int offset_w   = offset_w_def;
  localparam int index_w    = index_w_def;
  localparam int lines      = 1 << index_w;
  localparam int line_words = 1 << (offset_w - 2);
  localparam int n_requests = 400;
  localparam int max_cycles = n_requests * 40;

  logic        clk = 1'b0;
  logic        rstn;
  logic        flush;
  logic        ifu_arvalid;
  logic        ifu_arready;
  logic [31:0] ifu_araddr;
  logic        ifu_rvalid;
  logic        ifu_rready;
  logic [31:0] ifu_rdata;
  logic        mem_arvalid;
  logic        mem_arready;
  logic [31:0] mem_araddr;
  mem_len_t    mem_arlen;
  burst_kind_e mem_arburst;
  logic        mem_rvalid;
  mem_data_t   mem_rdata;
  logic        mem_rlast;
  perf_cnt_t   perf_hit;
  perf_cnt_t   perf_miss;
  perf_cnt_t   perf_bypass;

  logic [31:0] exp_addr;
  logic        exp_single;
  logic        burst_err;
  logic        outstanding;
  int unsigned rng_state = 49435;
  int unsigned cycles = 0;

  logic                         model_valid [lines];
  logic [31-offset_w-index_w:0] model_tag   [lines];
  perf_cnt_t                    n_hit;
  perf_cnt_t                    n_miss;
  perf_cnt_t                    n_bypass;

  always #2 clk = ~clk;

  icache_top #(.offset_w(offset_w), .index_w(index_w)) DUT (.*);

  mem_burst_model #(.line_words(line_words), .seed(49435)) u_mem (
    .clk, .rstn, .mem_arvalid, .mem_arready, .mem_araddr, .mem_arlen, .mem_arburst,
    .mem_rvalid, .mem_rdata, .mem_rlast, .exp_addr, .exp_single, .burst_err
  );

  function automatic logic [15:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[30:15];
  endfunction

  function automatic logic [31:0] word_mix(logic [31:0] addr);
    logic [31:0] w;
    w = {addr[31:2], 2'b00};
    return (w * 32'h9e3779b1) ^ {w[15:0], w[31:16]} ^ 32'h5a0f_c3a5;
  endfunction

  function automatic logic [31:0] pick_addr();
    logic [15:0] sel;
    sel = lcg_next();
    if (sel[1:0] < 2) // three tags fighting over the same lines
      return 32'h4000_0000 + 32'(lcg_next() % 3) * 32'(1 << (offset_w + index_w))
             + 32'(lcg_next() % 64);
    else if (sel[1:0] == 2)
      return 32'h1000_0000 + 32'(lcg_next() % 32); // sram window
    return {4'(3 + lcg_next() % 13), 12'(lcg_next()), lcg_next()};
  endfunction

  task automatic stop_on_failure();
    $display("tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_error(string what);
    $display("Error at time %0t: %s", $time, what);
    stop_on_failure();
  endtask

  task automatic check_word(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_count(perf_cnt_t got, perf_cnt_t exp, string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %0d expected %0d", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    for (int i = 0; i < lines; i++) begin
      model_valid[i] = 1'b0;
    end
  endtask

  task automatic run_request(logic [31:0] addr);
    logic [31:0]                  word_addr;
    logic                         single;
    logic                         expect_hit;
    logic [31:0]                  held;
    int unsigned                  idx;
    logic [31-offset_w-index_w:0] tag;
    word_addr  = {addr[31:2], 2'b00};
    single     = addr[31:28] < cacheable_base_nibble;
    idx        = word_addr[offset_w+index_w-1:offset_w];
    tag        = word_addr[31:offset_w+index_w];
    expect_hit = !single && model_valid[idx] && model_tag[idx] == tag;
    exp_addr   = word_addr;
    exp_single = single;
    ifu_arvalid = 1'b1;
    ifu_araddr  = addr;
    while (!ifu_arready) next_cycle();
    next_cycle(); // accepted here
    outstanding = 1'b1;
    ifu_araddr  = ~addr; // stays offered, must not be taken while busy
    if (expect_hit && !ifu_rvalid)
      report_error("hit response did not follow in the cycle after acceptance");
    while (!ifu_rvalid) begin
      if (ifu_arready)
        report_error("cache ready for a new request while one is outstanding");
      next_cycle();
    end
    held = ifu_rdata;
    ifu_rready = (lcg_next() % 4) != 0;
    while (!ifu_rready) begin
      next_cycle();
      if (!ifu_rvalid || ifu_arready)
        report_error("response dropped before the fetch unit accepted it");
      check_word(ifu_rdata, held, "response word changed while stalled");
      ifu_rready = (lcg_next() % 4) != 0;
    end
    next_cycle(); // response handshake
    ifu_rready  = 1'b0;
    ifu_arvalid = 1'b0;
    outstanding = 1'b0;
    check_word(held, word_mix(word_addr), "fetch word");
    if (single) begin
      n_bypass++;
    end else if (expect_hit) begin
      n_hit++;
    end else begin
      n_miss++;
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tag;
    end
    check_count(perf_hit, n_hit, "perf_hit");
    check_count(perf_miss, n_miss, "perf_miss");
    check_count(perf_bypass, n_bypass, "perf_bypass");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles)
      report_error("timeout, requests did not complete in time");
  end

  always @(negedge clk) begin
    if (burst_err)
      report_error("memory model rejected a burst");
    if (rstn && ifu_rvalid && !outstanding)
      report_error("fetch response with no request outstanding");
  end

  initial begin
    rstn        = 1'b0;
    flush       = 1'b0;
    ifu_arvalid = 1'b0;
    ifu_araddr  = '0;
    ifu_rready  = 1'b0;
    exp_addr    = '0;
    exp_single  = 1'b0;
    outstanding = 1'b0;
    n_hit       = '0;
    n_miss      = '0;
    n_bypass    = '0;
    for (int i = 0; i < lines; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
    for (int n = 0; n < n_requests; n++) begin
      if ((lcg_next() % 16) == 0)
        pulse_flush();
      run_request(pick_addr());
    end
    $display("all tests passed");
    $finish;
  end

endmodule
